// File: build.f
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/pc_unit.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/mem_arbiter.sv
hw/exec_unit.sv
hw/branch_core_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/core_trace.txt
# M addr word | R pc next_pc wen index data | S addr data (all hex)
# skipped slots hold 88a00077 (movi r5) and must never retire.
M 00000040 88200005
M 00000044 a0417ffb
M 00000048 886ffffd
M 0000004c 98220004
M 00000050 98224004
M 00000054 88a00077
M 00000058 9c420004
M 0000005c 88a00077
M 00000060 9c430004
M 00000064 9c640004
M 00000068 9c650004
M 0000006c 88a00077
M 00000070 9c260004
M 00000074 88a00077
M 00000078 9c270004
M 0000007c 98420004
M 00000080 88a00077
M 00000084 91000006
M 00000088 88a00077
M 0000008c 88a00077
M 00000090 886000a0
M 00000094 94001800
M 00000098 88a00077
M 0000009c 88a00077
M 000000a0 886000b0
M 000000a4 94001801
M 000000a8 88a00077
M 000000ac 88a00077
M 000000b0 08800100
M 000000b4 28200101
M 000000b8 08400101
M 000000bc 90000000
M 00000400 12345678
R 00000040 00000044 1 01 00000005
R 00000044 00000048 1 02 00000000
R 00000048 0000004c 1 03 fffffffd
R 0000004c 00000050 0 00 00000000
R 00000050 00000058 0 00 00000000
R 00000058 00000060 0 00 00000000
R 00000060 00000064 0 00 00000000
R 00000064 00000068 0 00 00000000
R 00000068 00000070 0 00 00000000
R 00000070 00000078 0 00 00000000
R 00000078 0000007c 0 00 00000000
R 0000007c 00000084 0 00 00000000
R 00000084 00000090 1 1e 00000088
R 00000090 00000094 1 03 000000a0
R 00000094 000000a0 0 00 00000000
R 000000a0 000000a4 1 03 000000b0
R 000000a4 000000b0 1 1e 000000a8
R 000000b0 000000b4 1 04 12345678
R 000000b4 000000b8 0 00 00000000
R 000000b8 000000bc 1 02 00000005
R 000000bc 000000bc 0 00 00000000
S 00000404 00000005

// File: sim/tb_top.sv
module tb_top;

	localparam int          max_records  = 64;
	localparam int          mem_words    = 1024;
	localparam logic [31:0] reset_vector = 32'h0000_0040;

	logic              clock;
	logic              reset;
	bus_pkg::mem_req_t mem_req;
	logic              mem_req_valid;
	logic              mem_req_ready;
	bus_pkg::mem_rsp_t mem_rsp;
	logic              mem_rsp_valid;
	logic              retire_valid;
	isa_pkg::retire_t  retire;
	logic [31:0]       mem [mem_words];
	isa_pkg::retire_t  exp_retire [max_records];
	logic [63:0]       exp_store [max_records];
	int                retire_total;
	int                store_total;
	logic [31:0]       lfsr;
	logic              rsp_pending;
	int                rsp_delay;
	bus_pkg::mem_req_t held_req;
	logic              trace_ok;
	logic              all_seen;
	int                mismatch_count;
	int                extra_count;
	int                retire_seen;
	int                store_seen;
	int                missing_count;
	int                cycles;
	int                cycle_limit;

	branch_core_top #(.reset_vector(reset_vector)) dut (
		.clock(clock), .reset(reset), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid),
		.retire_valid(retire_valid), .retire(retire)
	);

	tb_checker #(.max_records(max_records)) chk (
		.clock(clock), .reset(reset), .retire_valid(retire_valid), .retire(retire),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
		.exp_retire(exp_retire), .retire_total(retire_total), .exp_store(exp_store),
		.store_total(store_total), .all_seen(all_seen), .mismatch_count(mismatch_count),
		.extra_count(extra_count), .retire_seen(retire_seen), .store_seen(store_seen)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
	endfunction

	task automatic take_bits(input int n, output logic [3:0] bits);
		bits = 4'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[2:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (addr[31:12] == 20'd0)
			return mem[addr[11:2]];
		return addr ^ 32'h3c3c_a5a5;
	endfunction

	task automatic load_trace(output logic ok);
		integer      fd;
		integer      code;
		string       line;
		logic [31:0] a, b, c, d, e;
		ok = 1'b0;
		fd = $fopen("sim/core_trace.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0) begin
					case (line.getc(0))
						"M": begin
							code = $sscanf(line, "M %h %h", a, b);
							mem[a[11:2]] = b;
						end
						"R": begin
							code = $sscanf(line, "R %h %h %h %h %h", a, b, c, d, e);
							exp_retire[retire_total] = '{pc: a, next_pc: b, wen: c[0],
								widx: d[4:0], wdata: e};
							retire_total++;
						end
						"S": begin
							code = $sscanf(line, "S %h %h", a, b);
							exp_store[store_total] = {a, b};
							store_total++;
						end
						default: ; // comment lines.
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// ----------------------------------------
	// memory model with random back-pressure
	// ----------------------------------------
	always @(negedge clock) begin : memory
		logic [3:0] bits;
		if (reset) begin
			mem_req_ready = 1'b0;
			mem_rsp_valid = 1'b0;
			rsp_pending = 1'b0;
		end else begin
			mem_rsp_valid = 1'b0;
			if (rsp_pending && rsp_delay == 0) begin
				mem_rsp_valid = 1'b1;
				mem_rsp = '{rdata: held_req.write ? 32'd0 : mem_read(held_req.addr),
					id: held_req.id};
				rsp_pending = 1'b0;
			end else if (rsp_pending) begin
				rsp_delay--;
			end
			take_bits(2, bits);
			mem_req_ready = (bits[1:0] != 2'b00);
			// valid is a register, so this is the transfer of the coming rising edge.
			if (mem_req_valid && mem_req_ready && !rsp_pending) begin
				held_req = mem_req;
				if (mem_req.write && mem_req.addr[31:12] == 20'd0)
					mem[mem_req.addr[11:2]] = mem_req.wdata;
				take_bits(2, bits);
				rsp_delay = bits[1:0];
				rsp_pending = 1'b1;
			end
		end
	end

	initial begin
		reset = 1'b1;
		mem_req_ready = 1'b0;
		mem_rsp = '0;
		mem_rsp_valid = 1'b0;
		rsp_pending = 1'b0;
		rsp_delay = 0;
		lfsr = 32'd94287;
		retire_total = 0;
		store_total = 0;
		for (int i = 0; i < mem_words; i++)
			mem[i] = (i << 2) ^ 32'hc3c3_0000;
		load_trace(trace_ok);
		cycle_limit = 64 * (retire_total + store_total) + 100;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		cycles = 0;
		while (trace_ok && !all_seen && cycles < cycle_limit) begin
			@(negedge clock);
			cycles++;
		end
		missing_count = (retire_total - retire_seen) + (store_total - store_seen);
		if (!trace_ok)
			$display("could not open the trace file sim/core_trace.txt");
		else if (!all_seen)
			$display("timeout after %0d cycles, %0d expected records never seen",
				cycles, missing_count);
		$display("errors: mismatch %0d, missing %0d, extra %0d",
			mismatch_count, missing_count, extra_count);
		if (trace_ok && mismatch_count == 0 && missing_count == 0 && extra_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim/tb_checker.sv
module tb_checker #(
	parameter int max_records = 64
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              retire_valid,
	input  isa_pkg::retire_t  retire,
	input  logic              mem_req_valid,
	input  logic              mem_req_ready,
	input  bus_pkg::mem_req_t mem_req,
	input  isa_pkg::retire_t  exp_retire [max_records],
	input  int                retire_total,
	input  logic [63:0]       exp_store [max_records],
	input  int                store_total,
	output logic              all_seen,
	output int                mismatch_count,
	output int                extra_count,
	output int                retire_seen,
	output int                store_seen
);

	assign all_seen = (retire_seen == retire_total) && (store_seen == store_total);

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			mismatch_count++;
			$display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// ----------------------------------------
	// retire and store comparison
	// ----------------------------------------
	always @(posedge clock) begin : compare
		isa_pkg::retire_t want;
		if (reset) begin
			mismatch_count = 0;
			extra_count = 0;
			retire_seen = 0;
			store_seen = 0;
		end else begin
			if (retire_valid && retire_seen >= retire_total) begin
				extra_count++;
				$display("extra retire at time %0t with pc %h", $time, retire.pc);
			end else if (retire_valid) begin
				want = exp_retire[retire_seen];
				check_field("retire pc", retire.pc, want.pc);
				check_field("retire next_pc", retire.next_pc, want.next_pc);
				check_field("retire write enable", 32'(retire.wen), 32'(want.wen));
				if (want.wen) begin // index and data only matter on a write.
					check_field("retire write index", 32'(retire.widx), 32'(want.widx));
					check_field("retire write data", retire.wdata, want.wdata);
				end
				retire_seen++;
			end
			if (mem_req_valid && mem_req_ready && mem_req.write) begin
				if (store_seen >= store_total) begin
					extra_count++;
					$display("extra store at time %0t to address %h", $time, mem_req.addr);
				end else begin
					check_field("store address", mem_req.addr, exp_store[store_seen][63:32]);
					check_field("store data", mem_req.wdata, exp_store[store_seen][31:0]);
					store_seen++;
				end
			end
		end
	end

endmodule

// File: hw/branch_core_top.sv
module branch_core_top #(
	parameter logic [31:0] reset_vector = 32'h0000_0000
) (
	input  logic              clock,
	input  logic              reset,
	output bus_pkg::mem_req_t mem_req,
	output logic              mem_req_valid,
	input  logic              mem_req_ready,
	input  bus_pkg::mem_rsp_t mem_rsp,
	input  logic              mem_rsp_valid,
	output logic              retire_valid,
	output isa_pkg::retire_t  retire
);

	logic [31:0] fetch_pc;
	logic [31:0] target;
	logic        advance;
	logic        redirect;
	logic        link;
	logic        resolve;
	logic        fetch_req_valid;
	logic        fetch_req_ready;
	logic        fetch_rsp_valid;
	logic        instr_valid;
	logic        instr_take;
	logic [31:0] instr_word;
	logic [31:0] instr_pc;
	logic [31:0] rb_data;
	logic        ls_start;
	logic        ls_write;
	logic        ls_done;
	logic [31:0] ls_addr;
	logic [31:0] ls_wdata;
	logic [31:0] ls_rdata;
	logic        data_req_valid;
	logic        data_req_ready;
	logic        data_rsp_valid;
	logic [31:0] rsp_data;
	isa_pkg::instr_fields_t fields;
	isa_pkg::branch_flags_t flags;
	bus_pkg::mem_req_t      data_req;

	wire bus_pkg::mem_req_t fetch_req =
		'{addr: fetch_pc, write: 1'b0, wdata: 32'd0, id: bus_pkg::id_fetch};

	pc_unit #(.reset_vector(reset_vector)) u_pc (
		.clock(clock), .reset(reset), .advance(advance), .fields(fields),
		.instr_pc(instr_pc), .flags(flags), .rb_data(rb_data), .resolve(resolve),
		.fetch_pc(fetch_pc), .redirect(redirect), .link(link), .target(target)
	);

	fetch_unit u_fetch (
		.clock(clock), .reset(reset), .fetch_pc(fetch_pc), .redirect(redirect),
		.req_valid(fetch_req_valid), .req_ready(fetch_req_ready),
		.rsp_valid(fetch_rsp_valid), .rsp_data(rsp_data), .advance(advance),
		.instr_valid(instr_valid), .instr_word(instr_word), .instr_pc(instr_pc),
		.instr_take(instr_take)
	);

	exec_unit u_exec (
		.clock(clock), .reset(reset), .instr_valid(instr_valid),
		.instr_word(instr_word), .instr_pc(instr_pc), .instr_take(instr_take),
		.fields(fields), .flags(flags), .rb_data(rb_data), .resolve(resolve),
		.link(link), .redirect(redirect), .target(target), .ls_start(ls_start),
		.ls_write(ls_write), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
		.ls_done(ls_done), .ls_rdata(ls_rdata), .retire_valid(retire_valid),
		.retire(retire)
	);

	load_store_unit u_lsu (
		.clock(clock), .reset(reset), .start(ls_start), .write(ls_write),
		.addr(ls_addr), .wdata(ls_wdata), .req_valid(data_req_valid), .req(data_req),
		.req_ready(data_req_ready), .rsp_valid(data_rsp_valid), .rsp_data(rsp_data),
		.done(ls_done), .rdata(ls_rdata)
	);

	mem_arbiter u_arb (
		.clock(clock), .reset(reset), .fetch_req(fetch_req),
		.fetch_req_valid(fetch_req_valid), .fetch_req_ready(fetch_req_ready),
		.data_req(data_req), .data_req_valid(data_req_valid),
		.data_req_ready(data_req_ready), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid),
		.fetch_rsp_valid(fetch_rsp_valid), .data_rsp_valid(data_rsp_valid),
		.rsp_data(rsp_data)
	);

endmodule

// File: hw/exec_unit.sv
module exec_unit (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   instr_valid,
	input  logic [31:0]            instr_word,
	input  logic [31:0]            instr_pc,
	output logic                   instr_take,
	output isa_pkg::instr_fields_t fields,
	output isa_pkg::branch_flags_t flags,
	output logic [31:0]            rb_data,
	output logic                   resolve,
	input  logic                   link,
	input  logic                   redirect,
	input  logic [31:0]            target,
	output logic                   ls_start,
	output logic                   ls_write,
	output logic [31:0]            ls_addr,
	output logic [31:0]            ls_wdata,
	input  logic                   ls_done,
	input  logic [31:0]            ls_rdata,
	output logic                   retire_valid,
	output isa_pkg::retire_t       retire
);

	logic [31:0] regs [32];
	logic [31:0] rt_data;
	logic [31:0] ra_data;
	logic [31:0] imm15_ext;
	logic        is_mem;
	logic        mem_wait;
	logic        mem_load;
	logic [31:0] mem_pc;
	logic [4:0]  mem_rt;

	// ----------------------------------------
	// decode and operands
	// ----------------------------------------
	assign fields = isa_pkg::split_fields(instr_word);
	assign rt_data = regs[fields.rt];
	assign ra_data = regs[fields.ra];
	assign rb_data = regs[fields.rb];
	assign imm15_ext = {{17{fields.imm15[14]}}, fields.imm15};
	assign flags = '{rt_ra_equal: (rt_data == ra_data), rt_zero: (rt_data == 32'd0),
		rt_negative: rt_data[31]};

	assign is_mem = (fields.opcode == isa_pkg::op_lwi) || (fields.opcode == isa_pkg::op_swi);
	assign instr_take = instr_valid && !mem_wait; // one memory access at a time.
	assign resolve = instr_take && !is_mem;
	assign ls_start = instr_take && is_mem;
	assign ls_write = (fields.opcode == isa_pkg::op_swi);
	assign ls_addr = ra_data + (imm15_ext << 2); // word offset.
	assign ls_wdata = rt_data;

	always_ff @(posedge clock) begin
		if (reset)
			mem_wait <= 1'b0;
		else if (ls_start)
			mem_wait <= 1'b1;
		else if (ls_done)
			mem_wait <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (ls_start) begin
			mem_pc <= instr_pc;
			mem_rt <= fields.rt;
			mem_load <= (fields.opcode == isa_pkg::op_lwi);
		end
	end

	// ----------------------------------------
	// retire and write back
	// ----------------------------------------
	always_comb begin
		retire_valid = resolve || ls_done;
		if (ls_done) begin
			retire.pc = mem_pc;
			retire.next_pc = mem_pc + 32'd4;
			retire.wen = mem_load;
			retire.widx = mem_rt;
			retire.wdata = ls_rdata;
		end else begin
			retire.pc = instr_pc;
			retire.next_pc = redirect ? target : instr_pc + 32'd4;
			retire.wen = 1'b0;
			retire.widx = fields.rt;
			retire.wdata = 32'd0;
			case (fields.opcode)
				isa_pkg::op_movi: begin
					retire.wen = 1'b1;
					retire.wdata = {{12{fields.imm20[19]}}, fields.imm20};
				end
				isa_pkg::op_addi: begin
					retire.wen = 1'b1;
					retire.wdata = ra_data + imm15_ext;
				end
				default: begin
					if (link) begin
						retire.wen = 1'b1;
						retire.widx = isa_pkg::link_reg;
						retire.wdata = instr_pc + 32'd4;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (retire_valid && retire.wen) begin
			regs[retire.widx] <= retire.wdata;
		end
	end

endmodule

// File: hw/mem_arbiter.sv
module mem_arbiter (
	input  logic              clock,
	input  logic              reset,
	input  bus_pkg::mem_req_t fetch_req,
	input  logic              fetch_req_valid,
	output logic              fetch_req_ready,
	input  bus_pkg::mem_req_t data_req,
	input  logic              data_req_valid,
	output logic              data_req_ready,
	output bus_pkg::mem_req_t mem_req,
	output logic              mem_req_valid,
	input  logic              mem_req_ready,
	input  bus_pkg::mem_rsp_t mem_rsp,
	input  logic              mem_rsp_valid,
	output logic              fetch_rsp_valid,
	output logic              data_rsp_valid,
	output logic [31:0]       rsp_data
);

	logic busy;
	logic grant;

	assign data_req_ready = data_req_valid && !busy;
	assign fetch_req_ready = fetch_req_valid && !data_req_valid && !busy;
	assign grant = data_req_ready || fetch_req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			mem_req_valid <= 1'b0;
		end else if (grant) begin
			busy <= 1'b1;
			mem_req_valid <= 1'b1;
		end else begin
			if (mem_req_valid && mem_req_ready)
				mem_req_valid <= 1'b0;
			if (mem_rsp_valid)
				busy <= 1'b0;
		end
	end

	// the granted request is held here, so the port stays stable whatever the peers do.
	always_ff @(posedge clock) begin
		if (data_req_ready)
			mem_req <= data_req;
		else if (fetch_req_ready)
			mem_req <= fetch_req;
	end

	assign fetch_rsp_valid = mem_rsp_valid && (mem_rsp.id == bus_pkg::id_fetch);
	assign data_rsp_valid = mem_rsp_valid && (mem_rsp.id == bus_pkg::id_data);
	assign rsp_data = mem_rsp.rdata;

	// a response belongs to the one request that has already left the port.
	assert property (@(posedge clock) disable iff (reset)
		mem_rsp_valid |-> busy && !mem_req_valid);

endmodule

// File: hw/load_store_unit.sv
module load_store_unit (
	input  logic              clock,
	input  logic              reset,
	input  logic              start,
	input  logic              write,
	input  logic [31:0]       addr,
	input  logic [31:0]       wdata,
	output logic              req_valid,
	output bus_pkg::mem_req_t req,
	input  logic              req_ready,
	input  logic              rsp_valid,
	input  logic [31:0]       rsp_data,
	output logic              done,
	output logic [31:0]       rdata
);

	logic pending;
	logic waiting;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
			waiting <= 1'b0;
		end else begin
			if (start)
				pending <= 1'b1;
			else if (req_valid && req_ready)
				pending <= 1'b0;
			if (req_valid && req_ready)
				waiting <= 1'b1;
			else if (rsp_valid)
				waiting <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			req <= '{addr: addr, write: write, wdata: wdata, id: bus_pkg::id_data};
	end

	assign req_valid = pending;
	assign done = waiting && rsp_valid; // stores complete on their response too.
	assign rdata = rsp_data;

	assert property (@(posedge clock) disable iff (reset) start |-> !pending && !waiting);

endmodule

// File: hw/fetch_unit.sv
module fetch_unit (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] fetch_pc,
	input  logic        redirect,
	output logic        req_valid,
	input  logic        req_ready,
	input  logic        rsp_valid,
	input  logic [31:0] rsp_data,
	output logic        advance,
	output logic        instr_valid,
	output logic [31:0] instr_word,
	output logic [31:0] instr_pc,
	input  logic        instr_take
);

	logic        buf_valid;
	logic        inflight;
	logic [1:0]  stale_cnt;
	logic [31:0] inflight_pc;
	logic        rsp_live;

	// the answer must find the buffer empty, so ask only when it is free or being taken.
	assign req_valid = !inflight && (!buf_valid || instr_take) && !redirect;
	assign advance = req_valid && req_ready;
	assign rsp_live = rsp_valid && (stale_cnt == 2'd0) && !redirect;
	assign instr_valid = buf_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			buf_valid <= 1'b0;
			inflight <= 1'b0;
			stale_cnt <= 2'd0;
		end else begin
			if (advance)
				inflight <= 1'b1;
			else if (rsp_valid)
				inflight <= 1'b0;
			if (redirect)
				buf_valid <= 1'b0; // the prefetched word is on the wrong path.
			else if (rsp_live)
				buf_valid <= 1'b1;
			else if (instr_take)
				buf_valid <= 1'b0;
			if (redirect && inflight && !rsp_valid)
				stale_cnt <= stale_cnt + 2'd1;
			else if (rsp_valid && stale_cnt != 2'd0)
				stale_cnt <= stale_cnt - 2'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (advance)
			inflight_pc <= fetch_pc;
		if (rsp_live) begin
			instr_word <= rsp_data;
			instr_pc <= inflight_pc;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(rsp_valid && stale_cnt == 2'd0) |-> !buf_valid);

endmodule

// File: hw/pc_unit.sv
module pc_unit #(
	parameter logic [31:0] reset_vector = 32'h0000_0000
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   advance,
	input  isa_pkg::instr_fields_t fields,
	input  logic [31:0]            instr_pc,
	input  isa_pkg::branch_flags_t flags,
	input  logic [31:0]            rb_data,
	input  logic                   resolve,
	output logic [31:0]            fetch_pc,
	output logic                   redirect,
	output logic                   link,
	output logic [31:0]            target
);

	isa_pkg::pc_sel_t select_pc;
	logic bz_taken;

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_pc <= reset_vector;
		end else if (redirect) begin
			fetch_pc <= target; // a taken branch overrides the sequential step.
		end else if (advance) begin
			fetch_pc <= fetch_pc + 32'd4;
		end
	end

	// ----------------------------------------
	// next pc selection
	// ----------------------------------------
	always_comb begin
		case (fields.sub_bz)
			isa_pkg::bz_beqz: bz_taken = flags.rt_zero;
			isa_pkg::bz_bgez: bz_taken = !flags.rt_negative;
			isa_pkg::bz_bgtz: bz_taken = !flags.rt_zero && !flags.rt_negative;
			isa_pkg::bz_blez: bz_taken = flags.rt_zero || flags.rt_negative;
			isa_pkg::bz_bltz: bz_taken = flags.rt_negative;
			isa_pkg::bz_bnez: bz_taken = !flags.rt_zero;
			default:          bz_taken = 1'b0;
		endcase
	end

	always_comb begin
		select_pc = isa_pkg::sel_seq;
		case (fields.opcode)
			isa_pkg::op_b: begin
				if (fields.sub_b == isa_pkg::sub_beq && flags.rt_ra_equal)
					select_pc = isa_pkg::sel_off14;
				else if (fields.sub_b == isa_pkg::sub_bne && !flags.rt_ra_equal)
					select_pc = isa_pkg::sel_off14;
			end
			isa_pkg::op_bz: begin
				if (bz_taken)
					select_pc = isa_pkg::sel_off16;
			end
			isa_pkg::op_j:  select_pc = isa_pkg::sel_off24;
			isa_pkg::op_jr: select_pc = isa_pkg::sel_reg;
			default:        select_pc = isa_pkg::sel_seq;
		endcase
	end

	always_comb begin
		case (select_pc)
			isa_pkg::sel_off14:
				target = instr_pc + {{17{fields.imm14[13]}}, fields.imm14, 1'b0};
			isa_pkg::sel_off16:
				target = instr_pc + {{15{fields.imm16[15]}}, fields.imm16, 1'b0};
			isa_pkg::sel_off24:
				target = instr_pc + {{7{fields.imm24[23]}}, fields.imm24, 1'b0};
			isa_pkg::sel_reg:
				target = rb_data;
			default:
				target = instr_pc + 32'd4;
		endcase
	end

	assign redirect = resolve && (select_pc != isa_pkg::sel_seq);
	assign link = resolve && fields.link &&
		(fields.opcode == isa_pkg::op_j || fields.opcode == isa_pkg::op_jr);

	// register jump targets come from the register file and must stay word aligned.
	assert property (@(posedge clock) disable iff (reset) fetch_pc[1:0] == 2'b00);

endmodule

// File: hw/bus_pkg.sv
package bus_pkg;

	typedef enum logic {
		id_fetch = 1'b0,
		id_data  = 1'b1
	} req_id_t;

	// ----------------------------------------
	// memory port payloads
	// ----------------------------------------
	typedef struct packed {
		logic [31:0] addr;
		logic        write;
		logic [31:0] wdata;
		req_id_t     id; // echoed back in the response.
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		req_id_t     id;
	} mem_rsp_t;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

	// ----------------------------------------
	// opcodes and sub-operations
	// ----------------------------------------
	typedef enum logic [5:0] {
		op_lwi  = 6'b000010,
		op_swi  = 6'b001010,
		op_movi = 6'b100010,
		op_j    = 6'b100100, // j and jal.
		op_jr   = 6'b100101, // jr and jral.
		op_b    = 6'b100110, // beq and bne.
		op_bz   = 6'b100111,
		op_addi = 6'b101000
	} opcode_t;

	typedef enum logic [3:0] {
		bz_beqz = 4'b0010,
		bz_bnez = 4'b0011,
		bz_bgez = 4'b0100,
		bz_bltz = 4'b0101,
		bz_bgtz = 4'b0110,
		bz_blez = 4'b0111
	} bz_op_t;

	localparam logic sub_beq = 1'b0;
	localparam logic sub_bne = 1'b1;

	localparam logic [4:0] link_reg = 5'd30; // jal and jral write the return address here.

	// ----------------------------------------
	// decoded instruction
	// ----------------------------------------
	typedef struct packed {
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic        sub_b;
		bz_op_t      sub_bz;
		logic        link;
		logic [13:0] imm14;
		logic [14:0] imm15;
		logic [15:0] imm16;
		logic [19:0] imm20;
		logic [23:0] imm24;
	} instr_fields_t;

	typedef enum logic [2:0] {
		sel_seq,
		sel_off14,
		sel_off16,
		sel_off24,
		sel_reg
	} pc_sel_t;

	typedef struct packed {
		logic rt_ra_equal;
		logic rt_zero;
		logic rt_negative;
	} branch_flags_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic        wen;
		logic [4:0]  widx;
		logic [31:0] wdata;
	} retire_t;

	function automatic instr_fields_t split_fields(logic [31:0] word);
		instr_fields_t f;
		f.opcode = opcode_t'(word[31:26]);
		f.rt     = word[25:21];
		f.ra     = word[20:16];
		f.rb     = word[15:11];
		f.sub_b  = word[14];
		f.sub_bz = bz_op_t'(word[19:16]);
		f.link   = (word[31:26] == op_jr) ? word[0] : word[24]; // jr keeps its flag in bit 0.
		f.imm14  = word[13:0];
		f.imm15  = word[14:0];
		f.imm16  = word[15:0];
		f.imm20  = word[19:0];
		f.imm24  = word[23:0];
		return f;
	endfunction

endpackage
